// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module scoreboard_tb -f sim.f -o scoreboard_sim
	./obj_dir/scoreboard_sim > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "TESTS FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

// File: dv/scoreboard_checker.sv
// ====================
// scoreboard protocol checks
// four-phase rules on both channels and the hardwired register 0
// ====================

`timescale 1ns/1ps
`default_nettype none

module scoreboard_checker (
	input logic clk,
	input logic rst,
	input logic disp_req,
	input logic disp_ack,
	input logic cmt_req,
	input logic cmt_ack,
	input logic reg0_valid
);

	// an ack only ever answers a request that was up at the edge before it rose
	disp_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
		$rose(disp_ack) |-> $past(disp_req))
		else $error("disp_ack rose without a dispatch request");

	cmt_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
		$rose(cmt_ack) |-> $past(cmt_req))
		else $error("cmt_ack rose without a commit request");

	// once the requester lets go, ack is down by the following edge
	disp_ack_release: assert property (@(posedge clk) disable iff (rst)
		disp_ack && !disp_req |=> !disp_ack)
		else $error("disp_ack stayed high after disp_req dropped");

	cmt_ack_release: assert property (@(posedge clk) disable iff (rst)
		cmt_ack && !cmt_req |=> !cmt_ack)
		else $error("cmt_ack stayed high after cmt_req dropped");

	// register 0 is never pending, whatever dispatch or flush does
	reg0_always_valid: assert property (@(posedge clk) disable iff (rst) reg0_valid)
		else $error("register 0 was reported invalid");

endmodule

bind scoreboard_top scoreboard_checker i_checker (
	.clk        (clk),
	.rst        (rst),
	.disp_req   (disp_req),
	.disp_ack   (disp_ack),
	.cmt_req    (cmt_req),
	.cmt_ack    (cmt_ack),
	.reg0_valid (reg_valid[0])
);

`default_nettype wire

// File: dv/scoreboard_patterns.txt
// op a0 a1 a2 a3 tag rdy val reg_valid, op 1 dispatch a0, 2 commit a1 tag a2 tgt a3 rfw,
// 3 flush a0 keep_mask, 4 dispatch and commit together, rdy is rs1 in bit 1 and rs2 in bit 0
1 2305 0 0 0 0 3 0 fff7
1 1534 0 0 0 1 1 0 ffd7
1 2311 0 0 0 2 3 0 ffd7
2 0000 0 3 1 0 0 0 ffd7
1 3350 0 0 0 3 0 0 ffd7
2 0000 2 3 1 0 0 1 ffdf
1 1060 0 0 0 4 3 0 ffdf
1 2740 0 0 0 5 3 0 ff5f
1 2908 0 0 0 6 3 0 fd5f
3 0020 0 0 0 0 0 0 ff7f
4 1a79 5 7 1 7 3 1 fbff
1 4a20 0 0 0 8 2 0 fbff
2 0000 7 a 0 0 0 0 fbff
1 0000 0 0 0 9 3 0 fbff
2 0000 7 a 1 0 0 1 ffff
0 0000 0 0 0 0 0 0 0000

// File: dv/scoreboard_tb.sv
// ====================
// scoreboard testbench
// replays the pattern file through both handshakes and checks every answer
// ====================

`timescale 1ns/1ps
`default_nettype none

module scoreboard_tb;
	import sb_cfg_pkg::*;

	// a pattern line is op, four arguments, then tag, readiness, validated, reg_valid
	localparam int COLS = 9;
	localparam int MAX_OPS = 64;

	logic                clk = 1'b0;
	logic                rst;
	logic                disp_req;
	logic [15:0]         disp_instr;
	logic                disp_ack;
	sb_tag_t             disp_tag;
	logic                rs1_ready;
	logic                rs2_ready;
	logic                cmt_req;
	sb_tag_t             cmt_tag;
	sb_reg_t             cmt_tgt;
	logic                cmt_rfw;
	logic                cmt_ack;
	logic                cmt_validated;
	logic                flush;
	logic [2**TAG_W-1:0] keep_mask;
	logic [AREGS-1:0]    reg_valid;

	logic [15:0] pat [MAX_OPS*COLS];
	sb_tag_t     got_tag;
	logic        got_rs1;
	logic        got_rs2;
	logic        got_val;
	int          n_ops;
	int          limit;
	int          cycles;
	int          checks;
	int          errors;

	scoreboard_top #(
		.AREGS (AREGS),
		.TAG_W (TAG_W)
	) i_dut (
		.clk           (clk),
		.rst           (rst),
		.disp_req      (disp_req),
		.disp_instr    (disp_instr),
		.disp_ack      (disp_ack),
		.disp_tag      (disp_tag),
		.rs1_ready     (rs1_ready),
		.rs2_ready     (rs2_ready),
		.cmt_req       (cmt_req),
		.cmt_tag       (cmt_tag),
		.cmt_tgt       (cmt_tgt),
		.cmt_rfw       (cmt_rfw),
		.cmt_ack       (cmt_ack),
		.cmt_validated (cmt_validated),
		.flush         (flush),
		.keep_mask     (keep_mask),
		.reg_valid     (reg_valid)
	);

	always #5 clk = ~clk;

	// ====================
	// stimulus tasks
	// ====================

	// raises the chosen requests together so a same-cycle commit lands with the dispatch
	// answers are taken once every raised ack is up, then req is held a few random cycles
	task automatic run_handshake(input logic go_disp, input logic go_cmt);
		int unsigned idle;
		disp_req = go_disp;
		cmt_req = go_cmt;
		@(posedge clk);
		#1;
		while ((go_disp && !disp_ack) || (go_cmt && !cmt_ack)) begin
			@(posedge clk);
			#1;
		end
		got_tag = disp_tag;
		got_rs1 = rs1_ready;
		got_rs2 = rs2_ready;
		got_val = cmt_validated;
		idle = $urandom % 4;
		repeat (idle) begin
			@(posedge clk);
			#1;
		end
		disp_req = 1'b0;
		cmt_req = 1'b0;
		while (disp_ack || cmt_ack) begin
			@(posedge clk);
			#1;
		end
	endtask

	// flush is a single cycle pulse and is visible in reg_valid right after its edge
	task automatic pulse_flush(input logic [2**TAG_W-1:0] mask);
		flush = 1'b1;
		keep_mask = mask;
		@(posedge clk);
		#1;
		flush = 1'b0;
	endtask

	// the run is bounded by the pattern count, so a stuck handshake ends it here
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("Timeout after %0d cycles, a handshake never completed", cycles);
			$display("checks %0d, errors %0d", checks, errors + 1);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// ====================
	// main sequence
	// ====================

	initial begin
		int          base;
		logic [15:0] op;
		void'($urandom(35001));
		rst = 1'b1;
		disp_req = 1'b0;
		disp_instr = '0;
		cmt_req = 1'b0;
		cmt_tag = '0;
		cmt_tgt = '0;
		cmt_rfw = 1'b0;
		flush = 1'b0;
		keep_mask = '1;
		cycles = 0;
		checks = 0;
		errors = 0;
		limit = 0;
		n_ops = 0;
		$readmemh("dv/scoreboard_patterns.txt", pat);
		// the list ends at the first line whose op is not a known operation
		while (n_ops < MAX_OPS && pat[n_ops*COLS] inside {[16'h1:16'h4]}) n_ops++;
		limit = (n_ops + 1) * 12;
		if (n_ops == 0) begin
			$display("No operations were found in the pattern file");
			errors++;
		end
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		for (int k = 0; k < n_ops; k++) begin
			base = k * COLS;
			op = pat[base];
			disp_instr = pat[base+1];
			cmt_tag = pat[base+2][TAG_W-1:0];
			cmt_tgt = pat[base+3][REG_W-1:0];
			cmt_rfw = pat[base+4][0];
			case (op)
				16'h1: run_handshake(1'b1, 1'b0);
				16'h2: run_handshake(1'b0, 1'b1);
				16'h3: pulse_flush(pat[base+1]);
				default: run_handshake(1'b1, 1'b1);
			endcase
			if (op == 16'h1 || op == 16'h4) begin
				checks += 3;
				if (got_tag !== pat[base+5][TAG_W-1:0]) begin
					$display("Fail op %0d: disp_tag = %h, expected %h", k, got_tag,
						pat[base+5][TAG_W-1:0]);
					errors++;
				end
				if (got_rs1 !== pat[base+6][1]) begin
					$display("Fail op %0d: rs1_ready = %h, expected %h", k, got_rs1,
						pat[base+6][1]);
					errors++;
				end
				if (got_rs2 !== pat[base+6][0]) begin
					$display("Fail op %0d: rs2_ready = %h, expected %h", k, got_rs2,
						pat[base+6][0]);
					errors++;
				end
			end
			if (op == 16'h2 || op == 16'h4) begin
				checks++;
				if (got_val !== pat[base+7][0]) begin
					$display("Fail op %0d: cmt_validated = %h, expected %h", k, got_val,
						pat[base+7][0]);
					errors++;
				end
			end
			checks++;
			if (reg_valid !== pat[base+8][AREGS-1:0]) begin
				$display("Fail op %0d: reg_valid = %h, expected %h", k, reg_valid,
					pat[base+8][AREGS-1:0]);
				errors++;
			end
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
verilog/sb_cfg_pkg.sv
verilog/sb_isa_pkg.sv
verilog/sb_ifaces.sv
verilog/sb_decode.sv
verilog/reg_valid_table.sv
verilog/commit_result.sv
verilog/scoreboard_top.sv
dv/scoreboard_checker.sv
dv/scoreboard_tb.sv

// File: verilog/commit_result.sv
// ====================
// commit result port
// one commit per four-phase request, answering whether its register became valid
// ====================

`timescale 1ns/1ps
`default_nettype none

module commit_result (
	input  logic                clk,
	input  logic                rst,
	input  logic                cmt_req,
	input  sb_cfg_pkg::sb_tag_t cmt_tag,
	input  sb_cfg_pkg::sb_reg_t cmt_tgt,
	input  logic                cmt_rfw,
	output logic                cmt_ack,
	output logic                cmt_validated,
	commit_if.result            cmt
);
	import sb_cfg_pkg::*;

	typedef enum logic [1:0] {
		C_IDLE,
		C_PULSE,
		C_ACKED
	} state_t;

	state_t  state;
	sb_tag_t tag_q;
	sb_reg_t tgt_q;
	logic    rfw_q;
	logic    validated_q;

	// the commit goes out for exactly one cycle per request
	assign cmt.valid = (state == C_PULSE);
	assign cmt.tag = tag_q;
	assign cmt.tgt = tgt_q;
	assign cmt.rfw = rfw_q;

	// ack trails the pulse by one edge and holds until the requester lets go
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= C_IDLE;
		end else begin
			case (state)
				C_IDLE: if (cmt_req) state <= C_PULSE;
				C_PULSE: state <= C_ACKED;
				C_ACKED: if (!cmt_req) state <= C_IDLE;
				default: state <= C_IDLE;
			endcase
		end
	end

	// request fields are captured once and the answer is frozen with ack
	always_ff @(posedge clk) begin
		if (state == C_IDLE && cmt_req) begin
			tag_q <= cmt_tag;
			tgt_q <= cmt_tgt;
			rfw_q <= cmt_rfw;
		end
		if (state == C_PULSE) validated_q <= cmt.validated;
	end

	assign cmt_ack = (state == C_ACKED);
	assign cmt_validated = validated_q;

endmodule

`default_nettype wire

// File: verilog/reg_valid_table.sv
// ====================
// register valid table
// per register valid bit and pending source tag, with read-through readiness
// ====================

`timescale 1ns/1ps
`default_nettype none

module reg_valid_table #(
	parameter int AREGS = sb_cfg_pkg::AREGS,
	parameter int TAG_W = sb_cfg_pkg::TAG_W
) (
	input  logic                  clk,
	input  logic                  rst,
	dispatch_if.valid_table       dsp,
	commit_if.valid_table         cmt,
	input  logic                  flush,
	input  logic [2**TAG_W-1:0]   keep_mask,
	output logic [AREGS-1:0]      reg_valid
);

	logic [AREGS-1:0] valid_q;
	logic [AREGS-1:0] avail;
	logic [AREGS-1:0] valid_d;
	logic [TAG_W-1:0] src_tag [AREGS];
	logic [TAG_W-1:0] dsp_tag;
	logic [TAG_W-1:0] cmt_tag;
	logic             commit_hit;
	logic             disp_wr;

	assign dsp_tag = TAG_W'(dsp.tag);
	assign cmt_tag = TAG_W'(cmt.tag);

	// ====================
	// this edge's updates
	// ====================

	// the register may have been handed to a younger writer since this one issued,
	// so only a commit from the tag still on record may validate it
	assign commit_hit = cmt.valid && cmt.rfw && (cmt.tgt != '0)
		&& (src_tag[cmt.tgt] == cmt_tag);

	// register 0 is hardwired, so a write to it is never tracked
	assign disp_wr = dsp.valid && dsp.rfw && !flush && (dsp.rd != '0);

	// flush and commit results as seen by a reader in this cycle
	always_comb begin
		avail = valid_q;
		if (flush) begin
			// a pending register whose writer was squashed falls back to its old value
			for (int n = 1; n < AREGS; n++) begin
				if (!keep_mask[src_tag[n]]) avail[n] = 1'b1;
			end
		end
		if (commit_hit) avail[cmt.tgt] = 1'b1;
		avail[0] = 1'b1;
	end

	// a new writer wins over a commit landing on the same register
	always_comb begin
		valid_d = avail;
		if (disp_wr) valid_d[dsp.rd] = 1'b0;
		valid_d[0] = 1'b1;
	end

	// ====================
	// lookups
	// ====================

	// readers see the value before their own destination is invalidated,
	// and a field the opcode does not read never stalls
	assign dsp.rs1_ready = !dsp.rs1_used || avail[dsp.rs1];
	assign dsp.rs2_ready = !dsp.rs2_used || avail[dsp.rs2];

	// validated means this commit turned a pending register valid and kept it so
	assign cmt.validated = commit_hit && !valid_q[cmt.tgt] && valid_d[cmt.tgt];

	// ====================
	// state
	// ====================

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '1;
		end else begin
			valid_q <= valid_d;
		end
	end

	// tags are cleared too so that no register compares against a stale value
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int n = 0; n < AREGS; n++) begin
				src_tag[n] <= '0;
			end
		end else if (disp_wr) begin
			src_tag[dsp.rd] <= dsp_tag;
		end
	end

	assign reg_valid = valid_q;

endmodule

`default_nettype wire

// File: verilog/sb_cfg_pkg.sv
// ====================
// scoreboard configuration
// sizes of the register set and the tag space, and the index types built on them
// ====================

`default_nettype none

package sb_cfg_pkg;

	// ====================
	// sizes
	// ====================

	// number of architectural registers tracked by the valid table
	parameter int AREGS = 16;

	// width of an instruction tag, so 2**TAG_W tags can be live at once
	parameter int TAG_W = 4;

	// bits needed to name one architectural register
	parameter int REG_W = $clog2(AREGS);

	// ====================
	// index types
	// ====================

	// architectural register number as carried in the instruction word
	typedef logic [REG_W-1:0] sb_reg_t;

	// tag handed out at dispatch and returned at commit
	// the counter wraps, so the same tag comes back after 2**TAG_W dispatches
	typedef logic [TAG_W-1:0] sb_tag_t;

endpackage

`default_nettype wire

// File: verilog/sb_decode.sv
// ====================
// dispatch decode
// latches one instruction per four-phase request, decodes it and hands out a tag
// ====================

`timescale 1ns/1ps
`default_nettype none

module sb_decode #(
	parameter int TAG_W = sb_cfg_pkg::TAG_W
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  disp_req,
	input  sb_isa_pkg::sb_instr_u disp_instr,
	input  logic                  flush,
	output logic                  disp_ack,
	output sb_cfg_pkg::sb_tag_t   disp_tag,
	output logic                  rs1_ready,
	output logic                  rs2_ready,
	dispatch_if.decode            dsp
);
	import sb_cfg_pkg::*;
	import sb_isa_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_ISSUE,
		S_ACKED
	} state_t;

	state_t     state;
	logic [TAG_W-1:0] tag_cnt;
	sb_instr_u  instr_q;
	sb_op_e     op;
	sb_reg_t    dec_rd;
	sb_reg_t    dec_rs1;
	sb_reg_t    dec_rs2;
	logic       dec_rs1_used;
	logic       dec_rs2_used;

	// ====================
	// instruction decode
	// ====================

	// the opcode nibble is shared by both views, so either one gives it
	// STORE and BRANCH take their second source from the rd field
	// only the writing opcodes name a destination and the others leave rd at zero
	always_comb begin
		op = instr_q.r.op;
		dec_rd = '0;
		dec_rs1 = '0;
		dec_rs2 = '0;
		dec_rs1_used = 1'b0;
		dec_rs2_used = 1'b0;
		if (op_is_imm(op)) begin
			dec_rd = instr_q.i.rd;
		end else begin
			case (op)
				ALU_REG: begin
					dec_rd = instr_q.r.rd;
					dec_rs1 = instr_q.r.rs1;
					dec_rs2 = instr_q.r.rs2;
					dec_rs1_used = 1'b1;
					dec_rs2_used = 1'b1;
				end
				STORE, BRANCH: begin
					dec_rs1 = instr_q.r.rs1;
					dec_rs2 = instr_q.r.rd;
					dec_rs1_used = 1'b1;
					dec_rs2_used = 1'b1;
				end
				default: begin
					// NOP and unknown codes read nothing
				end
			endcase
		end
	end

	// valid is held back during a flush so the table never sees both at one edge
	assign dsp.valid = (state == S_ISSUE) && !flush;
	assign dsp.rd = dec_rd;
	assign dsp.rfw = op_writes_rd(op);
	assign dsp.tag = sb_tag_t'(tag_cnt);
	assign dsp.rs1 = dec_rs1;
	assign dsp.rs2 = dec_rs2;
	assign dsp.rs1_used = dec_rs1_used;
	assign dsp.rs2_used = dec_rs2_used;

	// ====================
	// handshake FSM
	// ====================

	assign disp_ack = (state == S_ACKED);

	// idle latches the word, issue waits out any flush, acked holds until req drops
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			tag_cnt <= '0;
		end else begin
			case (state)
				S_IDLE: if (disp_req) state <= S_ISSUE;
				S_ISSUE: begin
					if (!flush) begin
						state <= S_ACKED;
						tag_cnt <= tag_cnt + TAG_W'(1);
					end
				end
				S_ACKED: if (!disp_req) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	// the word and the answers are payload and only move on their strobes
	always_ff @(posedge clk) begin
		if (state == S_IDLE && disp_req) instr_q <= disp_instr;
		if (dsp.valid) begin
			disp_tag <= dsp.tag;
			rs1_ready <= dsp.rs1_ready;
			rs2_ready <= dsp.rs2_ready;
		end
	end

endmodule

`default_nettype wire

// File: verilog/sb_ifaces.sv
// ====================
// scoreboard internal buses
// dispatch bus from decode and commit bus from result, both into the valid table
// ====================

`timescale 1ns/1ps
`default_nettype none

// decode presents one decoded instruction per valid pulse
// the table answers with read-through readiness in the same cycle
interface dispatch_if;
	import sb_cfg_pkg::*;

	logic    valid;
	sb_reg_t rd;
	logic    rfw;
	sb_tag_t tag;
	sb_reg_t rs1;
	sb_reg_t rs2;
	logic    rs1_used;
	logic    rs2_used;
	logic    rs1_ready;
	logic    rs2_ready;

	modport decode (
		output valid, rd, rfw, tag, rs1, rs2, rs1_used, rs2_used,
		input  rs1_ready, rs2_ready
	);

	modport valid_table (
		input  valid, rd, rfw, tag, rs1, rs2, rs1_used, rs2_used,
		output rs1_ready, rs2_ready
	);
endinterface

// result presents one committing instruction per valid pulse
// validated comes back combinationally while valid is high
interface commit_if;
	import sb_cfg_pkg::*;

	logic    valid;
	sb_tag_t tag;
	sb_reg_t tgt;
	logic    rfw;
	logic    validated;

	modport result (output valid, tag, tgt, rfw, input validated);

	modport valid_table (input valid, tag, tgt, rfw, output validated);
endinterface

`default_nettype wire

// File: verilog/sb_isa_pkg.sv
// ====================
// scoreboard instruction set
// opcodes and the two views of the 16 bit instruction word
// ====================

`default_nettype none

package sb_isa_pkg;

	// the opcode sits in the top nibble of every word
	typedef enum logic [3:0] {
		NOP      = 4'h0,
		ALU_REG  = 4'h1,
		LOAD_IMM = 4'h2,
		STORE    = 4'h3,
		BRANCH   = 4'h4
	} sb_op_e;

	// register form used by ALU_REG, STORE and BRANCH
	// STORE and BRANCH have no destination and read the rd field as a source
	typedef struct packed {
		sb_op_e              op;
		sb_cfg_pkg::sb_reg_t rd;
		sb_cfg_pkg::sb_reg_t rs1;
		sb_cfg_pkg::sb_reg_t rs2;
	} sb_rform_t;

	// immediate form used by LOAD_IMM, which has no register sources
	typedef struct packed {
		sb_op_e              op;
		sb_cfg_pkg::sb_reg_t rd;
		logic [7:0]          imm;
	} sb_iform_t;

	// one word, two decodings, picked by the opcode
	typedef union packed {
		sb_rform_t r;
		sb_iform_t i;
	} sb_instr_u;

	// true for the opcodes that produce a register result
	function automatic logic op_writes_rd(input sb_op_e op);
		return (op == ALU_REG) || (op == LOAD_IMM);
	endfunction

	// true when the word must be read through the immediate view
	function automatic logic op_is_imm(input sb_op_e op);
		return op == LOAD_IMM;
	endfunction

endpackage

`default_nettype wire

// File: verilog/scoreboard_top.sv
// ====================
// register scoreboard top
// decode, valid table and commit result joined behind plain handshake ports
// ====================

`timescale 1ns/1ps
`default_nettype none

module scoreboard_top #(
	parameter int AREGS = sb_cfg_pkg::AREGS,
	parameter int TAG_W = sb_cfg_pkg::TAG_W
) (
	input  logic                     clk,
	input  logic                     rst,
	// dispatch channel
	input  logic                     disp_req,
	input  logic [15:0]              disp_instr,
	output logic                     disp_ack,
	output logic [TAG_W-1:0]         disp_tag,
	output logic                     rs1_ready,
	output logic                     rs2_ready,
	// commit channel
	input  logic                     cmt_req,
	input  logic [TAG_W-1:0]         cmt_tag,
	input  logic [$clog2(AREGS)-1:0] cmt_tgt,
	input  logic                     cmt_rfw,
	output logic                     cmt_ack,
	output logic                     cmt_validated,
	// flush and state
	input  logic                     flush,
	input  logic [2**TAG_W-1:0]      keep_mask,
	output logic [AREGS-1:0]         reg_valid
);

	dispatch_if dsp_bus ();
	commit_if   cmt_bus ();

	// front end turns the request into a decoded, tagged dispatch
	sb_decode #(
		.TAG_W      (TAG_W)
	) i_decode (
		.clk        (clk),
		.rst        (rst),
		.disp_req   (disp_req),
		.disp_instr (disp_instr),
		.flush      (flush),
		.disp_ack   (disp_ack),
		.disp_tag   (disp_tag),
		.rs1_ready  (rs1_ready),
		.rs2_ready  (rs2_ready),
		.dsp        (dsp_bus)
	);

	// the table sees dispatch, commit and flush of the same edge together
	reg_valid_table #(
		.AREGS      (AREGS),
		.TAG_W      (TAG_W)
	) i_table (
		.clk        (clk),
		.rst        (rst),
		.dsp        (dsp_bus),
		.cmt        (cmt_bus),
		.flush      (flush),
		.keep_mask  (keep_mask),
		.reg_valid  (reg_valid)
	);

	commit_result i_result (
		.clk           (clk),
		.rst           (rst),
		.cmt_req       (cmt_req),
		.cmt_tag       (cmt_tag),
		.cmt_tgt       (cmt_tgt),
		.cmt_rfw       (cmt_rfw),
		.cmt_ack       (cmt_ack),
		.cmt_validated (cmt_validated),
		.cmt           (cmt_bus)
	);

endmodule

`default_nettype wire
